// ==== sim.f ====
rtl/flight_pkg.sv
rtl/us_timebase.sv
rtl/rc_receiver.sv
rtl/angle_controller.sv
rtl/rate_controller.sv
rtl/motor_mixer.sv
rtl/esc_pwm.sv
rtl/flight_ctrl_top.sv
dv/flight_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the flight controller testbench

VERILATOR ?= verilator
TOP       ?= flight_ctrl_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/flight_ctrl_tb.sv ====
// Flight controller testbench
module flight_ctrl_tb import flight_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam real CLK_PERIOD = 10.0;
	localparam int  SEED       = 76;
	localparam int  N_RANDOM   = 6;  // Rounds of in-window sticks
	localparam int  N_REJECT   = 3;  // Rounds mixing in out-of-window pulses
	localparam int  N_LIMIT    = 4;  // Fixed extreme rounds
	localparam int  END_FRAMES = 3;  // ESC frames observed after the last sample
	// Every round fits in two frames, pulses included
	localparam int  TOTAL_FRAMES = 2 * (N_RANDOM + N_REJECT + N_LIMIT + 1) + END_FRAMES;
	localparam real WATCHDOG_NS  = 2.0 * TOTAL_FRAMES * FRAME_US * CLKS_PER_US * CLK_PERIOD;

	logic        sys_clk;
	logic        resetn;
	logic [3:0]  rc_pwm; // 0 throttle, 1 roll, 2 pitch, 3 yaw
	imu_sample_s imu;
	logic        imu_valid;
	logic [3:0]  pwm;
	motor_set_s  motor_cmd;
	logic        motor_cmd_valid;

	int         stick_m [4];      // Model stick values
	int         due_q [$];        // Cycle at which each result is due
	motor_set_s exp_q [$];        // Expected result per sample
	motor_set_s held_m = '0;      // Model of the ESC hold register
	motor_set_s held_d1 = '0;
	motor_set_s held_d2 = '0;     // Hold value as the frame tick sees it
	logic [3:0] pwm_q = '0;
	int         high_clks [4];
	int         frame_cmd [4];
	int         cycle_cnt = 0;
	int         frames_seen = 0;
	int         last_rise = 0;
	int         pulses_checked = 0;

	flight_ctrl_top i_flight_ctrl_top (
		.sys_clk         (sys_clk),
		.resetn          (resetn),
		.throttle_pwm    (rc_pwm[0]),
		.roll_pwm        (rc_pwm[1]),
		.pitch_pwm       (rc_pwm[2]),
		.yaw_pwm         (rc_pwm[3]),
		.imu             (imu),
		.imu_valid       (imu_valid),
		.pwm             (pwm),
		.motor_cmd       (motor_cmd),
		.motor_cmd_valid (motor_cmd_valid)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2.0) sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) cycle_cnt <= cycle_cnt + 1; // Read on falling edges only

	task automatic report_failure(string what);
		$display("[ERROR] %0d ns: %s", $time, what);
		$display("Regression failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(string name, int expected, int actual);
		if (expected != actual) begin
			$display("[ERROR] %0d ns %s: expected %0d, actual %0d", $time, name, expected, actual);
			$display("Regression failed");
			$fatal(1, "run stopped on first mismatch");
		end
	endtask

	function automatic int rand_range(int lo, int hi);
		return lo + int'($urandom % (hi - lo + 1));
	endfunction

	function automatic int limit_int(int v, int lim);
		if (v > lim) return lim;
		if (v < -lim) return -lim;
		return v;
	endfunction

	function automatic int clamp_full_scale(int v); // 0..STICK_MAX
		if (v < 0) return 0;
		if (v > STICK_MAX) return STICK_MAX;
		return v;
	endfunction

	function automatic int cmd_of(motor_set_s m, int i);
		case (i)
			0: return int'(m.motor1);
			1: return int'(m.motor2);
			2: return int'(m.motor3);
			default: return int'(m.motor4);
		endcase
	endfunction

	// Angle loop, rate loop and X mix from the current model sticks
	function automatic motor_set_s expected_motors(imu_sample_s s);
		int roll_tgt;
		int pitch_tgt;
		int yaw_tgt;
		int r;
		int p;
		int y;
		int t;
		motor_set_s m;
		roll_tgt  = limit_int((stick_m[1] - STICK_CENTER - int'(s.roll_angle)) >>> ANGLE_SHIFT,
		                      RATE_LIMIT);
		pitch_tgt = limit_int((stick_m[2] - STICK_CENTER - int'(s.pitch_angle)) >>> ANGLE_SHIFT,
		                      RATE_LIMIT);
		yaw_tgt   = stick_m[3] - STICK_CENTER; // Yaw stick is a rate command
		r = limit_int((roll_tgt - int'(s.roll_rate)) >>> RATE_SHIFT, CORR_LIMIT);
		p = limit_int((pitch_tgt - int'(s.pitch_rate)) >>> RATE_SHIFT, CORR_LIMIT);
		y = limit_int((yaw_tgt - int'(s.yaw_rate)) >>> RATE_SHIFT, CORR_LIMIT);
		t = stick_m[0];
		m = '0;
		if (t >= ARM_THRESHOLD) begin
			m.motor1 = motor_cmd_t'(clamp_full_scale(t + p + r - y));
			m.motor2 = motor_cmd_t'(clamp_full_scale(t + p - r + y));
			m.motor3 = motor_cmd_t'(clamp_full_scale(t - p - r - y));
			m.motor4 = motor_cmd_t'(clamp_full_scale(t - p + r + y));
		end
		return m;
	endfunction

	function automatic imu_sample_s random_sample(int angle_span, int rate_span);
		imu_sample_s s;
		s.roll_angle  = imu_val_t'(rand_range(-angle_span, angle_span));
		s.pitch_angle = imu_val_t'(rand_range(-angle_span, angle_span));
		s.yaw_angle   = imu_val_t'(rand_range(-angle_span, angle_span)); // Unused by the loops
		s.roll_rate   = imu_val_t'(rand_range(-rate_span, rate_span));
		s.pitch_rate  = imu_val_t'(rand_range(-rate_span, rate_span));
		s.yaw_rate    = imu_val_t'(rand_range(-rate_span, rate_span));
		return s;
	endfunction

	// Mostly out of window, sometimes a good pulse
	function automatic int mixed_width();
		if ($urandom % 3 == 0) return rand_range(PULSE_MIN_US, PULSE_MAX_US);
		if ($urandom % 2 == 0) return rand_range(100, PULSE_MIN_US - 1);
		return rand_range(PULSE_MAX_US + 1, 3000);
	endfunction

	// Pulse lasts a whole number of microsecond ticks
	task automatic send_pulse(int ch, int width_us);
		@(negedge sys_clk);
		rc_pwm[ch] = 1'b1;
		repeat (width_us * CLKS_PER_US) @(negedge sys_clk);
		rc_pwm[ch] = 1'b0;
	endtask

	task automatic send_sticks(int thr_us, int roll_us, int pitch_us, int yaw_us);
		int w [4];
		w = '{thr_us, roll_us, pitch_us, yaw_us};
		fork
			send_pulse(0, thr_us);
			send_pulse(1, roll_us);
			send_pulse(2, pitch_us);
			send_pulse(3, yaw_us);
		join
		for (int i = 0; i < 4; i++)
			if (w[i] >= PULSE_MIN_US && w[i] <= PULSE_MAX_US) // Glitch widths keep the old value
				stick_m[i] = clamp_full_scale(w[i] - STICK_BASE_US);
		repeat (4) @(negedge sys_clk); // Receiver needs 3 cycles after the fall
	endtask

	task automatic send_imu(imu_sample_s s);
		imu       = s;
		imu_valid = 1'b1;
		due_q.push_back(cycle_cnt + 3); // Fixed three stage latency
		exp_q.push_back(expected_motors(s));
		@(negedge sys_clk);
		imu_valid = 1'b0;
	endtask

	task automatic send_burst(int n, int angle_span, int rate_span);
		for (int i = 0; i < n; i++) begin
			send_imu(random_sample(angle_span, rate_span));
			repeat (rand_range(0, 3)) @(negedge sys_clk); // Zero gap gives back to back strobes
		end
	endtask

	// Result strobes, ESC pulse widths and frame spacing
	initial begin
		@(posedge resetn);
		forever begin
			@(negedge sys_clk);
			if (due_q.size() != 0 && due_q[0] == cycle_cnt) begin
				check_value("motor_cmd_valid", 1, int'(motor_cmd_valid));
				for (int i = 0; i < 4; i++)
					check_value($sformatf("motor_cmd.motor%0d", i + 1), cmd_of(exp_q[0], i),
					            cmd_of(motor_cmd, i));
				held_m = exp_q[0]; // ESC stage keeps the newest set
				void'(due_q.pop_front());
				void'(exp_q.pop_front());
			end else begin
				check_value("motor_cmd_valid", 0, int'(motor_cmd_valid));
			end
			if (pwm[0] && !pwm_q[0]) begin
				if (frames_seen > 0)
					check_value("ESC frame period", FRAME_US * CLKS_PER_US, cycle_cnt - last_rise);
				last_rise = cycle_cnt;
				frames_seen++;
			end
			for (int i = 0; i < 4; i++) begin
				if (pwm[i] && !pwm_q[i]) begin
					frame_cmd[i] = cmd_of(held_d2, i); // Latched at the frame tick
					high_clks[i] = 1;
				end else if (pwm[i]) begin
					high_clks[i]++;
				end else if (pwm_q[i]) begin
					check_value($sformatf("pwm[%0d] high clocks", i),
					            (STICK_BASE_US + frame_cmd[i]) * CLKS_PER_US, high_clks[i]);
					pulses_checked++;
				end
			end
			pwm_q   = pwm;
			held_d2 = held_d1;
			held_d1 = held_m;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure("watchdog expired, the run took longer than its frame budget");
	end

	initial begin
		int target;
		int waited;
		void'($urandom(SEED));
		resetn    = 1'b0;
		rc_pwm    = '0;
		imu       = '0;
		imu_valid = 1'b0;
		stick_m   = '{0, STICK_CENTER, STICK_CENTER, STICK_CENTER};
		repeat (10) @(negedge sys_clk);
		resetn = 1'b1;
		@(negedge sys_clk);
		check_value("pwm", 0, int'(pwm));
		for (int i = 0; i < 4; i++)
			check_value($sformatf("motor_cmd.motor%0d", i + 1), 0, cmd_of(motor_cmd, i));
		check_value("motor_cmd_valid", 0, int'(motor_cmd_valid));
		send_burst(2, 1000, 4000); // Throttle still 0, disarmed

		for (int r = 0; r < N_RANDOM; r++) begin
			send_sticks(rand_range(PULSE_MIN_US, PULSE_MAX_US), rand_range(PULSE_MIN_US, PULSE_MAX_US),
			            rand_range(PULSE_MIN_US, PULSE_MAX_US), rand_range(PULSE_MIN_US, PULSE_MAX_US));
			send_burst(8, 600, 2500);
		end
		for (int r = 0; r < N_REJECT; r++) begin
			send_sticks(mixed_width(), mixed_width(), mixed_width(), mixed_width());
			send_burst(6, 600, 2500);
		end

		send_sticks(2200, 2200, 800, 2200); // Full throttle, hard over
		send_imu({6{16'h7fff}});
		send_imu({6{16'h8000}});
		send_burst(6, 32767, 32767);
		send_sticks(1500, 1000, 2000, 1000); // Mid throttle, both clamp ends reachable
		send_burst(6, 32767, 32767);
		send_sticks(1049, 1500, 1500, 1500); // One below the arm threshold
		send_burst(4, 32767, 32767);
		send_sticks(1050, 1700, 1300, 1600); // Exactly at the threshold
		send_burst(4, 2000, 8000);

		target = frames_seen + END_FRAMES;
		waited = 0;
		while (frames_seen < target) begin
			@(negedge sys_clk);
			waited++;
			if (waited > (END_FRAMES + 1) * FRAME_US * CLKS_PER_US)
				report_failure("ESC frames stopped before the end of the run");
		end
		if (due_q.size() != 0 || pulses_checked == 0)
			report_failure("motor command strobes or ESC pulses missing at the end of the run");
		else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

// ==== rtl/flight_ctrl_top.sv ====
// Flight control datapath top
module flight_ctrl_top import flight_pkg::*; (
	input  logic        sys_clk,
	input  logic        resetn,
	input  logic        throttle_pwm,
	input  logic        roll_pwm,
	input  logic        pitch_pwm,
	input  logic        yaw_pwm,
	input  imu_sample_s imu,
	input  logic        imu_valid,
	output logic [3:0]  pwm,
	output motor_set_s  motor_cmd,
	output logic        motor_cmd_valid // 3 cycles after imu_valid
);

	logic        us_tick;
	logic        frame_tick;
	rc_sticks_s  sticks;
	rate_set_s   ac_rates;
	imu_sample_s ac_gyro; // Sample delayed one stage
	logic        ac_valid;
	rate_set_s   rc_corr;
	logic        rc_valid;

	us_timebase i_us_timebase (
		.sys_clk    (sys_clk),
		.resetn     (resetn),
		.us_tick    (us_tick),
		.frame_tick (frame_tick)
	);

	rc_receiver i_rc_receiver (
		.sys_clk      (sys_clk),
		.resetn       (resetn),
		.us_tick      (us_tick),
		.throttle_pwm (throttle_pwm),
		.roll_pwm     (roll_pwm),
		.pitch_pwm    (pitch_pwm),
		.yaw_pwm      (yaw_pwm),
		.sticks       (sticks)
	);

	angle_controller i_angle_controller (
		.sys_clk     (sys_clk),
		.resetn      (resetn),
		.sticks      (sticks),
		.imu         (imu),
		.imu_valid   (imu_valid),
		.rates       (ac_rates),
		.gyro        (ac_gyro),
		.rates_valid (ac_valid)
	);

	rate_controller i_rate_controller (
		.sys_clk       (sys_clk),
		.resetn        (resetn),
		.targets       (ac_rates),
		.targets_valid (ac_valid),
		.gyro          (ac_gyro),
		.corr          (rc_corr),
		.corr_valid    (rc_valid)
	);

	motor_mixer i_motor_mixer (
		.sys_clk      (sys_clk),
		.resetn       (resetn),
		.corr         (rc_corr),
		.corr_valid   (rc_valid),
		.motors       (motor_cmd),
		.motors_valid (motor_cmd_valid)
	);

	esc_pwm i_esc_pwm (
		.sys_clk      (sys_clk),
		.resetn       (resetn),
		.us_tick      (us_tick),
		.frame_tick   (frame_tick),
		.motors       (motor_cmd),
		.motors_valid (motor_cmd_valid),
		.pwm          (pwm)
	);

endmodule

// ==== rtl/esc_pwm.sv ====
// ESC pulse generator
module esc_pwm import flight_pkg::*; (
	input  logic       sys_clk,
	input  logic       resetn,
	input  logic       us_tick,
	input  logic       frame_tick,
	input  motor_set_s motors,
	input  logic       motors_valid,
	output logic [3:0] pwm
);

	localparam int PULSE_LIMIT_US = STICK_BASE_US + STICK_MAX; // 2000 us

	motor_set_s held;   // Newest command set
	motor_set_s active; // Set for the current frame
	motor_cmd_t cmd      [4];
	us_cnt_t    high_cnt [4]; // us ticks since the rising edge

	assign cmd[0] = active.motor1;
	assign cmd[1] = active.motor2;
	assign cmd[2] = active.motor3;
	assign cmd[3] = active.motor4;

	always_ff @(posedge sys_clk) begin
		if (!resetn)
			held <= '0;
		else if (motors_valid)
			held <= motors;
	end

	// Mid-frame updates wait for the next frame
	always_ff @(posedge sys_clk) begin
		if (frame_tick)
			active <= held;
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			pwm <= '0;
			for (int i = 0; i < 4; i++)
				high_cnt[i] <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (frame_tick) begin
					pwm[i]      <= 1'b1; // All pulses start together
					high_cnt[i] <= '0;
				end else if (pwm[i] && us_tick) begin
					if (high_cnt[i] == us_cnt_t'(STICK_BASE_US) + us_cnt_t'(cmd[i]) - 1'b1)
						pwm[i] <= 1'b0; // 1000 + cmd us elapsed
					high_cnt[i] <= high_cnt[i] + 1'b1;
				end
			end
		end
	end

	// A pulse never runs past the 2000 us ESC maximum
	for (genvar g = 0; g < 4; g++) begin : g_pulse_chk
		a_pulse_len: assert property (@(posedge sys_clk) disable iff (!resetn)
			pwm[g] |-> high_cnt[g] < us_cnt_t'(PULSE_LIMIT_US))
			else $error("ESC pulse %0d longer than 2000 us", g);
	end

endmodule

// ==== rtl/motor_mixer.sv ====
// X-frame motor mixer
module motor_mixer import flight_pkg::*; (
	input  logic       sys_clk,
	input  logic       resetn,
	input  rate_set_s  corr,
	input  logic       corr_valid,
	output motor_set_s motors,
	output logic       motors_valid
);

	acc_t t;
	acc_t p;
	acc_t r;
	acc_t y;
	logic armed;

	assign t     = acc_t'(corr.throttle);
	assign p     = acc_t'(corr.pitch);
	assign r     = acc_t'(corr.roll);
	assign y     = acc_t'(corr.yaw);
	assign armed = (t >= ARM_THRESHOLD);

	// Clamp a mixed sum to 0..STICK_MAX
	function automatic motor_cmd_t clamp_cmd(acc_t v);
		if (v < 0)
			return '0;
		else if (v > STICK_MAX)
			return motor_cmd_t'(STICK_MAX);
		return motor_cmd_t'(v);
	endfunction

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motors       <= '0; // Commands read as zero until the first sample
			motors_valid <= 1'b0;
		end else begin
			motors_valid <= corr_valid;
			if (corr_valid) begin
				if (armed) begin
					motors.motor1 <= clamp_cmd(t + p + r - y); // Front right, CCW
					motors.motor2 <= clamp_cmd(t + p - r + y);
					motors.motor3 <= clamp_cmd(t - p - r - y);
					motors.motor4 <= clamp_cmd(t - p + r + y);
				end else begin
					motors <= '0; // Disarmed, all idle
				end
			end
		end
	end

	// Commands handed to the ESC stage stay within full scale
	a_cmd_range: assert property (@(posedge sys_clk) disable iff (!resetn)
		corr_valid |=> motors.motor1 <= STICK_MAX && motors.motor2 <= STICK_MAX &&
		               motors.motor3 <= STICK_MAX && motors.motor4 <= STICK_MAX)
		else $error("motor command above STICK_MAX");

endmodule

// ==== rtl/rate_controller.sv ====
// Body rate loop, proportional only
module rate_controller import flight_pkg::*; (
	input  logic        sys_clk,
	input  logic        resetn,
	input  rate_set_s   targets,
	input  logic        targets_valid,
	input  imu_sample_s gyro,
	output rate_set_s   corr,
	output logic        corr_valid
);

	// Rate error, scaled and limited
	function automatic rate_t axis_corr(rate_t tgt, imu_val_t meas);
		acc_t err;
		err = acc_t'(tgt) - acc_t'(meas);
		return sat_rate(err >>> RATE_SHIFT, CORR_LIMIT);
	endfunction

	function automatic logic in_limit(rate_t v);
		return (v <= CORR_LIMIT) && (v >= -CORR_LIMIT);
	endfunction

	always_ff @(posedge sys_clk) begin
		if (!resetn)
			corr_valid <= 1'b0;
		else
			corr_valid <= targets_valid;
	end

	always_ff @(posedge sys_clk) begin
		if (targets_valid) begin
			corr.throttle <= targets.throttle; // Untouched by this loop
			corr.roll     <= axis_corr(targets.roll, gyro.roll_rate);
			corr.pitch    <= axis_corr(targets.pitch, gyro.pitch_rate);
			corr.yaw      <= axis_corr(targets.yaw, gyro.yaw_rate);
		end
	end

	// Every target set yields bounded corrections on the next cycle
	a_corr_limit: assert property (@(posedge sys_clk) disable iff (!resetn)
		targets_valid |=> in_limit(corr.roll) &&
		                  in_limit(corr.pitch) && in_limit(corr.yaw))
		else $error("correction outside CORR_LIMIT");

endmodule

// ==== rtl/angle_controller.sv ====
// Angle loop, proportional only
module angle_controller import flight_pkg::*; (
	input  logic        sys_clk,
	input  logic        resetn,
	input  rc_sticks_s  sticks,
	input  imu_sample_s imu,
	input  logic        imu_valid,
	output rate_set_s   rates,
	output imu_sample_s gyro,       // IMU sample delayed along with rates
	output logic        rates_valid
);

	// Stick offset from center, +-500
	function automatic acc_t centered(stick_t s);
		return acc_t'(s) - acc_t'(STICK_CENTER);
	endfunction

	// Target angle minus measured angle, scaled into a rate target
	function automatic rate_t angle_to_rate(stick_t s, imu_val_t angle);
		acc_t err;
		err = centered(s) - acc_t'(angle);
		return sat_rate(err >>> ANGLE_SHIFT, RATE_LIMIT);
	endfunction

	always_ff @(posedge sys_clk) begin
		if (!resetn)
			rates_valid <= 1'b0;
		else
			rates_valid <= imu_valid; // One stage of latency
	end

	// Payload only moves on a new sample
	always_ff @(posedge sys_clk) begin
		if (imu_valid) begin
			rates.throttle <= rate_t'(sticks.throttle); // Zero extended
			rates.roll     <= angle_to_rate(sticks.roll, imu.roll_angle);
			rates.pitch    <= angle_to_rate(sticks.pitch, imu.pitch_angle);
			rates.yaw      <= rate_t'(centered(sticks.yaw)); // Yaw stick is a rate command
			gyro           <= imu; // Keeps gyro rates aligned with these targets
		end
	end

endmodule

// ==== rtl/rc_receiver.sv ====
// RC servo pulse receiver
module rc_receiver import flight_pkg::*; (
	input  logic       sys_clk,
	input  logic       resetn,
	input  logic       us_tick,
	input  logic       throttle_pwm,
	input  logic       roll_pwm,
	input  logic       pitch_pwm,
	input  logic       yaw_pwm,
	output rc_sticks_s sticks
);

	localparam int N_CH = 4; // 0 throttle, 1 roll, 2 pitch, 3 yaw

	logic [N_CH-1:0] pwm_in;
	logic [N_CH-1:0] sync1;   // First synchronizer stage
	logic [N_CH-1:0] sync2;   // Second synchronizer stage
	logic [N_CH-1:0] level_q; // Edge register
	logic [N_CH-1:0] fall;
	us_cnt_t         width_cnt [N_CH]; // us ticks seen while high
	stick_t          stick_val [N_CH];

	assign pwm_in = {yaw_pwm, pitch_pwm, roll_pwm, throttle_pwm};
	assign fall   = level_q & ~sync2;

	// Clamp to 1000..2000 us, then remove the base
	function automatic stick_t to_stick(us_cnt_t w);
		us_cnt_t c;
		if (w < us_cnt_t'(STICK_BASE_US))
			c = us_cnt_t'(STICK_BASE_US);
		else if (w > us_cnt_t'(STICK_BASE_US + STICK_MAX))
			c = us_cnt_t'(STICK_BASE_US + STICK_MAX);
		else
			c = w;
		return stick_t'(c - us_cnt_t'(STICK_BASE_US));
	endfunction

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			sync1   <= '0;
			sync2   <= '0;
			level_q <= '0;
			for (int i = 0; i < N_CH; i++) begin
				width_cnt[i] <= '0;
				stick_val[i] <= (i == 0) ? '0 : stick_t'(STICK_CENTER); // Throttle idles low
			end
		end else begin
			sync1   <= pwm_in;
			sync2   <= sync1;
			level_q <= sync2;
			for (int i = 0; i < N_CH; i++) begin
				if (fall[i]) begin
					// Out-of-window pulses are glitches, keep the old value
					if (width_cnt[i] >= us_cnt_t'(PULSE_MIN_US) &&
					    width_cnt[i] <= us_cnt_t'(PULSE_MAX_US))
						stick_val[i] <= to_stick(width_cnt[i]);
					width_cnt[i] <= '0;
				end else if (sync2[i] && us_tick && width_cnt[i] != '1) begin
					width_cnt[i] <= width_cnt[i] + 1'b1; // Saturates on a stuck-high input
				end
			end
		end
	end

	assign sticks.throttle = stick_val[0];
	assign sticks.roll     = stick_val[1];
	assign sticks.pitch    = stick_val[2];
	assign sticks.yaw      = stick_val[3];

	// An accepted pulse never produces more than full stick
	a_stick_range: assert property (@(posedge sys_clk) disable iff (!resetn)
		|fall |=> sticks.throttle <= STICK_MAX && sticks.roll <= STICK_MAX &&
		          sticks.pitch <= STICK_MAX && sticks.yaw <= STICK_MAX)
		else $error("stick value above full scale");

endmodule

// ==== rtl/us_timebase.sv ====
// Microsecond and frame tick generator
module us_timebase import flight_pkg::*; (
	input  logic sys_clk,
	input  logic resetn,
	output logic us_tick,   // One cycle every CLKS_PER_US clocks
	output logic frame_tick // One cycle every FRAME_US us, aligned to us_tick
);

	localparam int CYC_W = $clog2(CLKS_PER_US);

	logic [CYC_W-1:0] clk_cnt; // Cycles within the current us
	us_cnt_t          us_cnt;  // Microseconds within the current frame
	logic             us_wrap;
	logic             frame_wrap;

	assign us_wrap    = (clk_cnt == CYC_W'(CLKS_PER_US - 1));
	assign frame_wrap = (us_cnt == us_cnt_t'(FRAME_US - 1));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			clk_cnt    <= '0;
			us_cnt     <= '0;
			us_tick    <= 1'b0;
			frame_tick <= 1'b0;
		end else begin
			us_tick    <= us_wrap;
			frame_tick <= us_wrap && frame_wrap; // Lands on a us_tick
			clk_cnt    <= us_wrap ? '0 : clk_cnt + 1'b1;
			if (us_wrap)
				us_cnt <= frame_wrap ? '0 : us_cnt + 1'b1;
		end
	end

endmodule

// ==== rtl/flight_pkg.sv ====
// Flight controller definitions
package flight_pkg;

	// Timing
	localparam int CLKS_PER_US   = 38;   // sys_clk cycles per microsecond
	localparam int FRAME_US      = 2500; // ESC frame period in us

	// Receiver pulse window
	localparam int PULSE_MIN_US  = 800;
	localparam int PULSE_MAX_US  = 2200;
	localparam int STICK_BASE_US = 1000; // Also the ESC idle pulse width
	localparam int STICK_MAX     = 1000; // Full stick, full motor command
	localparam int STICK_CENTER  = 500;  // Stick value for zero angle or rate

	// Proportional gains as right shifts, plus limits
	localparam int ANGLE_SHIFT   = 1;
	localparam int RATE_SHIFT    = 2;
	localparam int RATE_LIMIT    = 2047;
	localparam int CORR_LIMIT    = 250;
	localparam int ARM_THRESHOLD = 50;   // Motors idle below this throttle

	typedef logic [10:0]        stick_t;     // 0..STICK_MAX
	typedef logic signed [15:0] imu_val_t;   // Raw IMU angle or rate
	typedef logic signed [15:0] rate_t;      // Rate target or correction
	typedef logic [10:0]        motor_cmd_t; // 0..STICK_MAX
	typedef logic [11:0]        us_cnt_t;    // Microsecond count within a frame
	typedef logic signed [19:0] acc_t;       // Headroom for sums and differences

	typedef struct packed {
		stick_t throttle;
		stick_t roll;
		stick_t pitch;
		stick_t yaw;
	} rc_sticks_s;

	typedef struct packed {
		imu_val_t roll_angle;
		imu_val_t pitch_angle;
		imu_val_t yaw_angle;
		imu_val_t roll_rate;  // Gyro rates
		imu_val_t pitch_rate;
		imu_val_t yaw_rate;
	} imu_sample_s;

	typedef struct packed {
		rate_t throttle; // Carried along unsigned in a signed field
		rate_t roll;
		rate_t pitch;
		rate_t yaw;
	} rate_set_s;

	typedef struct packed {
		motor_cmd_t motor1;
		motor_cmd_t motor2;
		motor_cmd_t motor3;
		motor_cmd_t motor4;
	} motor_set_s;

	// Symmetric saturation to +-lim
	function automatic rate_t sat_rate(acc_t v, int lim);
		if (v > lim)
			return rate_t'(lim);
		else if (v < -lim)
			return rate_t'(-lim);
		return rate_t'(v);
	endfunction

endpackage
